//--- design/fpu_ss_pkg.sv
// Shared types for the floating-point offload unit
// Instruction union, channel structs, decoded instruction and opcodes

package fpu_ss_pkg;

  typedef logic [3:0] id_t;
  typedef logic [4:0] fpr_addr_t;

  // Major opcodes of the supported F instructions
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
  localparam logic [6:0] OPC_OP_FP    = 7'b1010011;

  // --------------------
  // Instruction word
  // --------------------
  typedef struct packed {
    logic [11:0] imm;
    fpr_addr_t   rs1;
    logic [2:0]  funct3;
    fpr_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Upper immediate half doubles as funct7 for OP-FP
  typedef struct packed {
    logic [6:0] imm_hi;
    fpr_addr_t  rs2;
    fpr_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef union packed {
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
  } fpu_instr_u;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_MV_W_X,
    OP_MV_X_W,
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_LOAD,
    OP_STORE
  } fpu_op_e;

  typedef struct packed {
    fpu_op_e     op;
    fpr_addr_t   rd;
    fpr_addr_t   rs1;
    fpr_addr_t   rs2;
    logic        rd_is_fp;
    logic        use_rs1_fp;
    logic        use_rs2_fp;
    logic [2:0]  funct3;
    logic [11:0] offset;
  } dec_instr_t;

  // --------------------
  // Offload channels
  // --------------------
  typedef struct packed {
    fpu_instr_u  instr;
    logic [31:0] rs1;
    id_t         id;
  } x_issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
    logic loadstore;
  } x_issue_resp_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    logic [2:0]  size;
    id_t         id;
  } x_mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    id_t         id;
  } x_mem_result_t;

  typedef struct packed {
    id_t         id;
    logic [31:0] data;
    fpr_addr_t   rd;
    logic        we;
  } x_result_t;

  // Outstanding load bookkeeping
  typedef struct packed {
    id_t       id;
    fpr_addr_t rd;
  } load_meta_t;

endpackage

//--- design/fpu_ss_decoder.sv
// Predecode and decode of offloaded F instruction words
// Fills the decoded struct and the issue response

module fpu_ss_decoder (
  input  fpu_ss_pkg::fpu_instr_u    instr_i,
  output fpu_ss_pkg::dec_instr_t    dec_o,
  output fpu_ss_pkg::x_issue_resp_t resp_o
);

  fpu_ss_pkg::fpu_op_e op;
  logic [6:0]          funct7;
  logic [2:0]          funct3;
  logic                is_sgnj;

  assign funct7 = instr_i.s_fmt.imm_hi;
  assign funct3 = instr_i.i_fmt.funct3;

  // Operation select, anything unmatched stays OP_NONE
  always_comb begin
    op = fpu_ss_pkg::OP_NONE;
    case (instr_i.i_fmt.opcode)
      fpu_ss_pkg::OPC_LOAD_FP: begin
        if (funct3 == 3'b010) op = fpu_ss_pkg::OP_LOAD;
      end
      fpu_ss_pkg::OPC_STORE_FP: begin
        if (funct3 == 3'b010) op = fpu_ss_pkg::OP_STORE;
      end
      fpu_ss_pkg::OPC_OP_FP: begin
        case (funct7)
          7'b0010000: begin
            case (funct3)
              3'b000:  op = fpu_ss_pkg::OP_SGNJ;
              3'b001:  op = fpu_ss_pkg::OP_SGNJN;
              3'b010:  op = fpu_ss_pkg::OP_SGNJX;
              default: op = fpu_ss_pkg::OP_NONE;
            endcase
          end
          7'b1111000: begin
            if (instr_i.s_fmt.rs2 == '0 && funct3 == 3'b000) op = fpu_ss_pkg::OP_MV_W_X;
          end
          7'b1110000: begin
            if (instr_i.s_fmt.rs2 == '0 && funct3 == 3'b000) op = fpu_ss_pkg::OP_MV_X_W;
          end
          default: op = fpu_ss_pkg::OP_NONE;
        endcase
      end
      default: op = fpu_ss_pkg::OP_NONE;
    endcase
  end

  assign is_sgnj = (op == fpu_ss_pkg::OP_SGNJ) || (op == fpu_ss_pkg::OP_SGNJN) ||
                   (op == fpu_ss_pkg::OP_SGNJX);

  // Register usage follows the operation
  always_comb begin
    dec_o            = '0;
    dec_o.op         = op;
    dec_o.rd         = instr_i.i_fmt.rd;
    dec_o.rs1        = instr_i.i_fmt.rs1;
    dec_o.rs2        = instr_i.s_fmt.rs2;
    dec_o.funct3     = funct3;
    dec_o.rd_is_fp   = is_sgnj || (op == fpu_ss_pkg::OP_MV_W_X) || (op == fpu_ss_pkg::OP_LOAD);
    dec_o.use_rs1_fp = is_sgnj || (op == fpu_ss_pkg::OP_MV_X_W);
    dec_o.use_rs2_fp = is_sgnj || (op == fpu_ss_pkg::OP_STORE);
    // S-type splits the immediate around rd
    if (op == fpu_ss_pkg::OP_STORE) begin
      dec_o.offset = {instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
    end else begin
      dec_o.offset = instr_i.i_fmt.imm;
    end
  end

  assign resp_o.accept    = (op != fpu_ss_pkg::OP_NONE);
  assign resp_o.writeback = (op == fpu_ss_pkg::OP_MV_X_W);
  assign resp_o.loadstore = (op == fpu_ss_pkg::OP_LOAD) || (op == fpu_ss_pkg::OP_STORE);

endmodule

//--- design/fpu_ss_regfile.sv
// Floating-point register file, 32 x 32 bits
// Two combinational read ports, two write ports

module fpu_ss_regfile (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  fpu_ss_pkg::fpr_addr_t raddr_a_i,
  input  fpu_ss_pkg::fpr_addr_t raddr_b_i,
  output logic [31:0]           rdata_a_o,
  output logic [31:0]           rdata_b_o,
  input  logic                  we_a_i,
  input  fpu_ss_pkg::fpr_addr_t waddr_a_i,
  input  logic [31:0]           wdata_a_i,
  input  logic                  we_b_i,
  input  fpu_ss_pkg::fpr_addr_t waddr_b_i,
  input  logic [31:0]           wdata_b_i
);

  logic [31:0][31:0] regs_q;

  // Port B is the load path and takes priority
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      regs_q <= '0;
    end else begin
      if (we_a_i) regs_q[waddr_a_i] <= wdata_a_i;
      if (we_b_i) regs_q[waddr_b_i] <= wdata_b_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

//--- design/fpu_ss_load_tracker.sv
// Outstanding load tracker
// In-order metadata FIFO, pending-register mask, load writeback

module fpu_ss_load_tracker #(
  parameter int MEM_FIFO_DEPTH = 3
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  fpu_ss_pkg::dec_instr_t    dec_i,
  input  logic                      push_i,
  input  fpu_ss_pkg::load_meta_t    push_meta_i,
  output logic                      full_o,
  output logic                      hazard_o,
  input  logic                      mem_result_valid_i,
  input  fpu_ss_pkg::x_mem_result_t mem_result_i,
  output logic                      we_o,
  output fpu_ss_pkg::fpr_addr_t     waddr_o,
  output logic [31:0]               wdata_o
);

  localparam int PTR_W = (MEM_FIFO_DEPTH > 1) ? $clog2(MEM_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(MEM_FIFO_DEPTH + 1);

  fpu_ss_pkg::load_meta_t fifo_q [MEM_FIFO_DEPTH];
  fpu_ss_pkg::load_meta_t head;
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic [31:0]            pending_q;
  logic [31:0]            set_mask;
  logic [31:0]            clr_mask;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(MEM_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head   = fifo_q[rd_ptr_q];
  assign full_o = (count_q == CNT_W'(MEM_FIFO_DEPTH));

  // --------------------
  // Metadata FIFO
  // --------------------
  always_ff @(posedge clk_i) begin
    if (push_i) fifo_q[wr_ptr_q] <= push_meta_i;
  end

  // A result pops every cycle it is valid, no back-pressure
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (mem_result_valid_i) rd_ptr_q <= ptr_next(rd_ptr_q);
      if (push_i && !mem_result_valid_i) begin
        count_q <= count_q + 1'b1;
      end else if (!push_i && mem_result_valid_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // --------------------
  // Pending registers
  // --------------------
  assign set_mask = push_i ? (32'd1 << push_meta_i.rd) : '0;
  assign clr_mask = mem_result_valid_i ? (32'd1 << head.rd) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr_mask) | set_mask;
    end
  end

  // Covers RAW on sources and WAW on rd
  assign hazard_o = (dec_i.use_rs1_fp && pending_q[dec_i.rs1]) ||
                    (dec_i.use_rs2_fp && pending_q[dec_i.rs2]) ||
                    (dec_i.rd_is_fp && pending_q[dec_i.rd]);

  assign we_o    = mem_result_valid_i;
  assign waddr_o = head.rd;
  assign wdata_o = mem_result_i.rdata;

endmodule

//--- design/fpu_ss_exec.sv
// Single instruction stage of the offload unit
// Sign injection, moves, address calculation, result and memory requests

module fpu_ss_exec (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      issue_valid_i,
  input  fpu_ss_pkg::x_issue_req_t  issue_req_i,
  input  fpu_ss_pkg::dec_instr_t    dec_i,
  input  logic                      accept_i,
  input  logic                      hazard_i,
  input  logic                      load_full_i,
  input  logic [31:0]               rdata_a_i,
  input  logic [31:0]               rdata_b_i,
  output logic                      issue_ready_o,
  output logic                      mem_valid_o,
  input  logic                      mem_ready_i,
  output fpu_ss_pkg::x_mem_req_t    mem_req_o,
  output logic                      load_push_o,
  output fpu_ss_pkg::load_meta_t    load_meta_o,
  output logic                      result_valid_o,
  input  logic                      result_ready_i,
  output fpu_ss_pkg::x_result_t     result_o,
  output logic                      fp_we_o,
  output fpu_ss_pkg::fpr_addr_t     fp_waddr_o,
  output logic [31:0]               fp_wdata_o
);

  typedef struct packed {
    fpu_ss_pkg::dec_instr_t dec;
    fpu_ss_pkg::id_t        id;
    logic [31:0]            op_a;
    logic [31:0]            op_b;
    logic [31:0]            int_rs1;
  } stage_t;

  stage_t      stage_q;
  logic        busy_q;
  logic        started_q;
  logic        take;
  logic        is_mem;
  logic        is_load;
  logic        mem_fire;
  logic        res_fire;
  logic [31:0] fp_val;

  assign take     = issue_valid_i && issue_ready_o && accept_i;
  assign is_load  = (stage_q.dec.op == fpu_ss_pkg::OP_LOAD);
  assign is_mem   = is_load || (stage_q.dec.op == fpu_ss_pkg::OP_STORE);
  assign mem_fire = mem_valid_o && mem_ready_i;
  assign res_fire = result_valid_o && result_ready_i;

  // Issue is held off for the first edge after reset
  assign issue_ready_o = started_q && !busy_q && !hazard_i;

  // --------------------
  // Stage register
  // --------------------
  always_ff @(posedge clk_i) begin
    if (take) begin
      stage_q.dec     <= dec_i;
      stage_q.id      <= issue_req_i.id;
      stage_q.op_a    <= rdata_a_i;
      stage_q.op_b    <= rdata_b_i;
      stage_q.int_rs1 <= issue_req_i.rs1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      started_q <= 1'b0;
    end else begin
      started_q <= 1'b1;
      if (take) begin
        busy_q <= 1'b1;
      end else if (mem_fire || res_fire) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Sign injection keeps the magnitude of rs1
  always_comb begin
    case (stage_q.dec.op)
      fpu_ss_pkg::OP_SGNJ:  fp_val = {stage_q.op_b[31], stage_q.op_a[30:0]};
      fpu_ss_pkg::OP_SGNJN: fp_val = {~stage_q.op_b[31], stage_q.op_a[30:0]};
      fpu_ss_pkg::OP_SGNJX: fp_val = {stage_q.op_a[31] ^ stage_q.op_b[31], stage_q.op_a[30:0]};
      fpu_ss_pkg::OP_MV_W_X: fp_val = stage_q.int_rs1;
      default:              fp_val = stage_q.op_a;
    endcase
  end

  // --------------------
  // Result channel
  // --------------------
  assign result_valid_o = busy_q && !is_mem;
  assign result_o.id    = stage_q.id;
  assign result_o.data  = fp_val;
  assign result_o.rd    = stage_q.dec.rd;
  assign result_o.we    = !stage_q.dec.rd_is_fp;

  assign fp_we_o    = res_fire && stage_q.dec.rd_is_fp;
  assign fp_waddr_o = stage_q.dec.rd;
  assign fp_wdata_o = fp_val;

  // --------------------
  // Memory channel
  // --------------------
  // A load waits for room in the tracker
  assign mem_valid_o     = busy_q && is_mem && !(is_load && load_full_i);
  assign mem_req_o.addr  = stage_q.int_rs1 + {{20{stage_q.dec.offset[11]}}, stage_q.dec.offset};
  assign mem_req_o.wdata = stage_q.op_b;
  assign mem_req_o.we    = !is_load;
  assign mem_req_o.size  = stage_q.dec.funct3;
  assign mem_req_o.id    = stage_q.id;

  assign load_push_o    = mem_fire && is_load;
  assign load_meta_o.id = stage_q.id;
  assign load_meta_o.rd = stage_q.dec.rd;

endmodule

//--- design/fpu_ss_top.sv
// Top level of the floating-point offload unit
// Connects the offload channels to decoder, register file, tracker and stage

module fpu_ss_top #(
  parameter int MEM_FIFO_DEPTH = 3
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      x_issue_valid_i,
  input  fpu_ss_pkg::x_issue_req_t  x_issue_req_i,
  output logic                      x_issue_ready_o,
  output fpu_ss_pkg::x_issue_resp_t x_issue_resp_o,
  output logic                      x_mem_valid_o,
  input  logic                      x_mem_ready_i,
  output fpu_ss_pkg::x_mem_req_t    x_mem_req_o,
  input  logic                      x_mem_result_valid_i,
  input  fpu_ss_pkg::x_mem_result_t x_mem_result_i,
  output logic                      x_result_valid_o,
  input  logic                      x_result_ready_i,
  output fpu_ss_pkg::x_result_t     x_result_o
);

  fpu_ss_pkg::dec_instr_t dec;
  fpu_ss_pkg::load_meta_t load_meta;
  fpu_ss_pkg::fpr_addr_t  fp_waddr_a;
  fpu_ss_pkg::fpr_addr_t  fp_waddr_b;
  logic [31:0]            rdata_a;
  logic [31:0]            rdata_b;
  logic [31:0]            fp_wdata_a;
  logic [31:0]            fp_wdata_b;
  logic                   fp_we_a;
  logic                   fp_we_b;
  logic                   load_push;
  logic                   load_full;
  logic                   hazard;

  fpu_ss_decoder i_decoder (
    .instr_i (x_issue_req_i.instr),
    .dec_o   (dec),
    .resp_o  (x_issue_resp_o)
  );

  // Operand reads follow the decoded source fields
  fpu_ss_regfile i_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_a_i    (fp_we_a),
    .waddr_a_i (fp_waddr_a),
    .wdata_a_i (fp_wdata_a),
    .we_b_i    (fp_we_b),
    .waddr_b_i (fp_waddr_b),
    .wdata_b_i (fp_wdata_b)
  );

  fpu_ss_load_tracker #(
    .MEM_FIFO_DEPTH (MEM_FIFO_DEPTH)
  ) i_load_tracker (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .dec_i              (dec),
    .push_i             (load_push),
    .push_meta_i        (load_meta),
    .full_o             (load_full),
    .hazard_o           (hazard),
    .mem_result_valid_i (x_mem_result_valid_i),
    .mem_result_i       (x_mem_result_i),
    .we_o               (fp_we_b),
    .waddr_o            (fp_waddr_b),
    .wdata_o            (fp_wdata_b)
  );

  fpu_ss_exec i_exec (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .issue_valid_i  (x_issue_valid_i),
    .issue_req_i    (x_issue_req_i),
    .dec_i          (dec),
    .accept_i       (x_issue_resp_o.accept),
    .hazard_i       (hazard),
    .load_full_i    (load_full),
    .rdata_a_i      (rdata_a),
    .rdata_b_i      (rdata_b),
    .issue_ready_o  (x_issue_ready_o),
    .mem_valid_o    (x_mem_valid_o),
    .mem_ready_i    (x_mem_ready_i),
    .mem_req_o      (x_mem_req_o),
    .load_push_o    (load_push),
    .load_meta_o    (load_meta),
    .result_valid_o (x_result_valid_o),
    .result_ready_i (x_result_ready_i),
    .result_o       (x_result_o),
    .fp_we_o        (fp_we_a),
    .fp_waddr_o     (fp_waddr_a),
    .fp_wdata_o     (fp_wdata_a)
  );

endmodule

//--- tests/fpu_ss_asserts.sv
// Handshake assertions for the instruction stage
// Attached to fpu_ss_exec with bind

module fpu_ss_asserts (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   issue_valid_i,
  input logic                   accept_i,
  input logic                   issue_ready_i,
  input logic                   mem_valid_i,
  input logic                   mem_ready_i,
  input fpu_ss_pkg::x_mem_req_t mem_req_i,
  input logic                   result_valid_i,
  input logic                   result_ready_i,
  input fpu_ss_pkg::x_result_t  result_i,
  input logic                   load_push_i,
  input logic                   load_full_i
);

  // Result held until the core takes it
  result_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_i))
    else $error("Result valid dropped or payload changed before ready");

  // Memory request held until the core takes it
  mem_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_req_i))
    else $error("Memory valid dropped or request changed before ready");

  // A taken instruction occupies the stage on the next cycle
  take_blocks_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i && issue_ready_i && accept_i |=> !issue_ready_i)
    else $error("Issue ready raised while the stage holds an instruction");

  push_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(load_push_i && load_full_i))
    else $error("Load metadata pushed into a full tracker");

endmodule

bind fpu_ss_exec fpu_ss_asserts i_asserts (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .issue_valid_i  (issue_valid_i),
  .accept_i       (accept_i),
  .issue_ready_i  (issue_ready_o),
  .mem_valid_i    (mem_valid_o),
  .mem_ready_i    (mem_ready_i),
  .mem_req_i      (mem_req_o),
  .result_valid_i (result_valid_o),
  .result_ready_i (result_ready_i),
  .result_i       (result_o),
  .load_push_i    (load_push_o),
  .load_full_i    (load_full_i)
);

//--- tests/fpu_ss_tb.sv
// Testbench for the floating-point offload unit
// Core and memory model, stimulus table, compare tasks

module fpu_ss_tb;

  localparam int          CLK_PERIOD     = 100;
  localparam int          NUM_ROWS       = 19;
  localparam int          TIMEOUT_CYCLES = 40 * NUM_ROWS + 10;
  localparam logic [31:0] LFSR_SEED      = 32'h800afe2e;
  localparam logic [31:0] LFSR_TAPS      = 32'ha3000000;
  localparam logic [6:0]  F7_SGNJ        = 7'b0010000;
  localparam logic [6:0]  F7_MV_X_W      = 7'b1110000;
  localparam logic [6:0]  F7_MV_W_X      = 7'b1111000;
  localparam logic [6:0]  OPC_STORE      = 7'b0100111;

  typedef enum logic [1:0] {K_RESULT, K_MEM, K_REJECT} kind_e;

  typedef struct packed {
    logic [31:0]     instr;
    logic [31:0]     rs1;
    fpu_ss_pkg::id_t id;
    kind_e           kind;
  } row_t;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      x_issue_valid_i;
  fpu_ss_pkg::x_issue_req_t  x_issue_req_i;
  logic                      x_issue_ready_o;
  fpu_ss_pkg::x_issue_resp_t x_issue_resp_o;
  logic                      x_mem_valid_o;
  logic                      x_mem_ready_i;
  fpu_ss_pkg::x_mem_req_t    x_mem_req_o;
  logic                      x_mem_result_valid_i;
  fpu_ss_pkg::x_mem_result_t x_mem_result_i;
  logic                      x_result_valid_o;
  logic                      x_result_ready_i;
  fpu_ss_pkg::x_result_t     x_result_o;

  row_t                      rows [NUM_ROWS];
  logic [31:0]               fregs [32];
  logic [31:0]               mem_words [logic [31:0]];
  fpu_ss_pkg::x_mem_result_t load_q [$];
  logic [31:0]               lfsr_q = LFSR_SEED;
  logic [2:0]                resp_delay = '0;
  int                        err_cnt = 0;
  int                        check_cnt = 0;
  int                        out_cnt = 0;
  int                        cycle_cnt = 0;

  // Channel activity sampled at the rising edge
  logic                      issue_fire_q = 1'b0;
  logic                      res_fire_q = 1'b0;
  logic                      mem_fire_q = 1'b0;
  fpu_ss_pkg::x_issue_resp_t resp_q;
  fpu_ss_pkg::x_result_t     res_q;
  fpu_ss_pkg::x_mem_req_t    mem_req_q;

  fpu_ss_top #(
    .MEM_FIFO_DEPTH (3)
  ) i_dut (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .x_issue_valid_i      (x_issue_valid_i),
    .x_issue_req_i        (x_issue_req_i),
    .x_issue_ready_o      (x_issue_ready_o),
    .x_issue_resp_o       (x_issue_resp_o),
    .x_mem_valid_o        (x_mem_valid_o),
    .x_mem_ready_i        (x_mem_ready_i),
    .x_mem_req_o          (x_mem_req_o),
    .x_mem_result_valid_i (x_mem_result_valid_i),
    .x_mem_result_i       (x_mem_result_i),
    .x_result_valid_o     (x_result_valid_o),
    .x_result_ready_i     (x_result_ready_i),
    .x_result_o           (x_result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic next_bit();
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    return lfsr_q[0];
  endfunction

  // Unwritten words follow the whole address
  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    if (mem_words.exists(addr)) return mem_words[addr];
    return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] op_fp_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b1010011};
  endfunction

  function automatic logic [31:0] load_word(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [4:0] rd);
    return {imm, rs1, 3'b010, rd, 7'b0000111};
  endfunction

  function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic injected_sign(input logic [2:0] f3, input logic sa, input logic sb);
    case (f3)
      3'b000:  return sb;
      3'b001:  return ~sb;
      default: return sa ^ sb;
    endcase
  endfunction

  function automatic string result_str(input fpu_ss_pkg::x_result_t r);
    return $sformatf("id=%h data=%h rd=%0d we=%b", r.id, r.data, r.rd, r.we);
  endfunction

  function automatic string mem_req_str(input fpu_ss_pkg::x_mem_req_t m);
    return $sformatf("addr=%h wdata=%h we=%b size=%0d id=%h",
                     m.addr, m.wdata, m.we, m.size, m.id);
  endfunction

  task automatic fill_table();
    rows[0]  = '{op_fp_word(F7_MV_X_W, 5'd0, 5'd3, 3'b000, 5'd5), 32'h0, 4'd1, K_RESULT};
    rows[1]  = '{op_fp_word(F7_MV_W_X, 5'd0, 5'd11, 3'b000, 5'd1), 32'h3f80_0000, 4'd2, K_RESULT};
    rows[2]  = '{op_fp_word(F7_MV_W_X, 5'd0, 5'd12, 3'b000, 5'd2), 32'hc020_0000, 4'd3, K_RESULT};
    rows[3]  = '{op_fp_word(F7_MV_X_W, 5'd0, 5'd1, 3'b000, 5'd6), 32'h0, 4'd4, K_RESULT};
    rows[4]  = '{op_fp_word(F7_SGNJ, 5'd2, 5'd1, 3'b000, 5'd3), 32'h0, 4'd5, K_RESULT};
    rows[5]  = '{op_fp_word(F7_MV_X_W, 5'd0, 5'd3, 3'b000, 5'd7), 32'h0, 4'd6, K_RESULT};
    rows[6]  = '{op_fp_word(F7_SGNJ, 5'd1, 5'd1, 3'b001, 5'd4), 32'h0, 4'd7, K_RESULT};
    rows[7]  = '{op_fp_word(F7_MV_X_W, 5'd0, 5'd4, 3'b000, 5'd8), 32'h0, 4'd8, K_RESULT};
    rows[8]  = '{op_fp_word(F7_SGNJ, 5'd2, 5'd2, 3'b010, 5'd5), 32'h0, 4'd9, K_RESULT};
    rows[9]  = '{op_fp_word(F7_MV_X_W, 5'd0, 5'd5, 3'b000, 5'd9), 32'h0, 4'd10, K_RESULT};
    rows[10] = '{store_word(12'hff8, 5'd3, 5'd10), 32'h0000_1000, 4'd11, K_MEM};
    rows[11] = '{load_word(12'hff8, 5'd10, 5'd6), 32'h0000_1000, 4'd12, K_MEM};
    // Back-to-back loads, then reads that stall on them
    rows[12] = '{load_word(12'h010, 5'd11, 5'd7), 32'h0000_2000, 4'd13, K_MEM};
    rows[13] = '{load_word(12'h7fc, 5'd12, 5'd8), 32'h0000_3000, 4'd14, K_MEM};
    rows[14] = '{op_fp_word(F7_MV_X_W, 5'd0, 5'd7, 3'b000, 5'd8), 32'h0, 4'd15, K_RESULT};
    rows[15] = '{op_fp_word(F7_MV_X_W, 5'd0, 5'd8, 3'b000, 5'd9), 32'h0, 4'd0, K_RESULT};
    rows[16] = '{op_fp_word(F7_MV_X_W, 5'd0, 5'd6, 3'b000, 5'd10), 32'h0, 4'd1, K_RESULT};
    // addi x1, x0, 5
    rows[17] = '{32'h0050_0093, 32'h0, 4'd2, K_REJECT};
    rows[18] = '{store_word(12'h024, 5'd8, 5'd13), 32'h0000_4000, 4'd3, K_MEM};
  endtask

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("ERR %0t %s: got %b, expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_resp(input fpu_ss_pkg::x_issue_resp_t got,
                            input fpu_ss_pkg::x_issue_resp_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("ERR %0t x_issue_resp_o: got acc=%b wb=%b ls=%b, expected acc=%b wb=%b ls=%b",
               $time, got.accept, got.writeback, got.loadstore,
               exp.accept, exp.writeback, exp.loadstore);
      err_cnt++;
    end
  endtask

  task automatic check_result(input fpu_ss_pkg::x_result_t got,
                              input fpu_ss_pkg::x_result_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("ERR %0t x_result_o: got %s, expected %s",
               $time, result_str(got), result_str(exp));
      err_cnt++;
    end
  endtask

  // Load write data carries no meaning
  task automatic check_mem_req(input fpu_ss_pkg::x_mem_req_t got,
                               input fpu_ss_pkg::x_mem_req_t exp);
    fpu_ss_pkg::x_mem_req_t cmp;
    cmp = got;
    if (!exp.we) cmp.wdata = exp.wdata;
    check_cnt++;
    if (cmp !== exp) begin
      $display("ERR %0t x_mem_req_o: got %s, expected %s",
               $time, mem_req_str(got), mem_req_str(exp));
      err_cnt++;
    end
  endtask

  // --------------------
  // Core and memory side
  // --------------------
  always @(posedge clk_i) begin
    issue_fire_q <= x_issue_valid_i && x_issue_ready_o && x_issue_resp_o.accept;
    resp_q       <= x_issue_resp_o;
    res_fire_q   <= x_result_valid_o && x_result_ready_i;
    res_q        <= x_result_o;
    mem_fire_q   <= x_mem_valid_o && x_mem_ready_i;
    mem_req_q    <= x_mem_req_o;
    if (x_result_valid_o || x_mem_valid_o) out_cnt <= out_cnt + 1;
  end

  // Stores land in the word array, loads queue their data in order
  always @(posedge clk_i) begin
    if (x_mem_valid_o && x_mem_ready_i) begin
      if (x_mem_req_o.we) begin
        mem_words[x_mem_req_o.addr] = x_mem_req_o.wdata;
      end else begin
        load_q.push_back({mem_read(x_mem_req_o.addr), x_mem_req_o.id});
      end
    end
  end

  always @(negedge clk_i) begin
    x_mem_ready_i        = next_bit();
    x_result_ready_i     = next_bit();
    x_mem_result_valid_i = 1'b0;
    if (load_q.size() != 0) begin
      if (resp_delay == '0) begin
        x_mem_result_valid_i = 1'b1;
        x_mem_result_i       = load_q.pop_front();
        resp_delay           = {next_bit(), next_bit(), next_bit()};
      end else begin
        resp_delay = resp_delay - 3'd1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic run_row(input int n);
    row_t                      r;
    logic [31:0]               w;
    logic [31:0]               val;
    fpu_ss_pkg::x_result_t     exp_res;
    fpu_ss_pkg::x_mem_req_t    exp_mem;
    fpu_ss_pkg::x_issue_resp_t exp_resp;
    int                        errs_before;
    int                        outs_before;
    r           = rows[n];
    w           = r.instr;
    errs_before = err_cnt;
    exp_resp.accept    = (r.kind != K_REJECT);
    exp_resp.writeback = (r.kind == K_RESULT) && (w[31:25] == F7_MV_X_W);
    exp_resp.loadstore = (r.kind == K_MEM);
    @(negedge clk_i);
    x_issue_valid_i     = 1'b1;
    x_issue_req_i.instr = w;
    x_issue_req_i.rs1   = r.rs1;
    x_issue_req_i.id    = r.id;
    if (r.kind == K_REJECT) begin
      outs_before = out_cnt;
      @(negedge clk_i);
      check_resp(resp_q, exp_resp);
      x_issue_valid_i = 1'b0;
      repeat (4) @(negedge clk_i);
      if (out_cnt != outs_before) begin
        $display("Row %0d: rejected instruction still produced an output", n);
        err_cnt++;
      end
    end else begin
      do begin
        @(negedge clk_i);
      end while (!issue_fire_q);
      x_issue_valid_i = 1'b0;
      check_resp(resp_q, exp_resp);
      if (r.kind == K_RESULT) begin
        case (w[31:25])
          F7_MV_X_W: val = fregs[w[19:15]];
          F7_MV_W_X: val = r.rs1;
          default: begin
            val = {injected_sign(w[14:12], fregs[w[19:15]][31], fregs[w[24:20]][31]),
                   fregs[w[19:15]][30:0]};
          end
        endcase
        exp_res.id   = r.id;
        exp_res.data = val;
        exp_res.rd   = w[11:7];
        exp_res.we   = (w[31:25] == F7_MV_X_W);
        do begin
          @(negedge clk_i);
        end while (!res_fire_q);
        check_result(res_q, exp_res);
        if (!exp_res.we) fregs[w[11:7]] = val;
      end else begin
        if (w[6:0] == OPC_STORE) begin
          exp_mem.addr  = r.rs1 + {{20{w[31]}}, w[31:25], w[11:7]};
          exp_mem.wdata = fregs[w[24:20]];
          exp_mem.we    = 1'b1;
        end else begin
          exp_mem.addr  = r.rs1 + {{20{w[31]}}, w[31:20]};
          exp_mem.wdata = '0;
          exp_mem.we    = 1'b0;
        end
        exp_mem.size = w[14:12];
        exp_mem.id   = r.id;
        do begin
          @(negedge clk_i);
        end while (!mem_fire_q);
        check_mem_req(mem_req_q, exp_mem);
        if (!exp_mem.we) fregs[w[11:7]] = mem_read(exp_mem.addr);
      end
    end
    $display("row %0d %s: %s", n, r.kind.name(), (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    rst_n_i              = 1'b0;
    x_issue_valid_i      = 1'b0;
    x_issue_req_i        = '0;
    x_mem_ready_i        = 1'b0;
    x_mem_result_valid_i = 1'b0;
    x_mem_result_i       = '0;
    x_result_ready_i     = 1'b0;
    for (int i = 0; i < 32; i++) fregs[i] = '0;
    fill_table();
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    // Outputs stay low until the first edge after release
    check_flag("x_issue_ready_o", x_issue_ready_o, 1'b0);
    check_flag("x_mem_valid_o", x_mem_valid_o, 1'b0);
    check_flag("x_result_valid_o", x_result_valid_o, 1'b0);
    $display("reset: %s", (err_cnt == 0) ? "ok" : "mismatch");
    for (int n = 0; n < NUM_ROWS; n++) run_row(n);
    while (load_q.size() != 0) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
design/fpu_ss_pkg.sv
design/fpu_ss_decoder.sv
design/fpu_ss_regfile.sv
design/fpu_ss_load_tracker.sv
design/fpu_ss_exec.sv
design/fpu_ss_top.sv
tests/fpu_ss_asserts.sv
tests/fpu_ss_tb.sv

//--- run.sh
#!/bin/sh
# Builds the offload unit and its testbench with Verilator, then runs the simulation

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module fpu_ss_tb -f vlog.f -o fpu_ss_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/fpu_ss_sim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation ended with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "Simulation log holds no verdict"
  exit 1
fi

exit 0
